// ==== design/data_ram.sv ====
module data_ram #(
    parameter int ram_addr_w = 10
) (
    input  logic                  clk,
    input  logic                  en,
    input  logic [3:0]            we,
    input  logic [ram_addr_w-1:0] addr,
    input  logic [31:0]           wdata,
    output logic [31:0]           rdata
);

    localparam int depth = 1 << ram_addr_w;

    logic [31:0] mem [0:depth-1];

    // read-first: a write returns the old word
    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= mem[addr];
            for (int i = 0; i < 4; i++) begin
                if (we[i]) begin
                    mem[addr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

// ==== design/lsu_pipe_top.sv ====
module lsu_pipe_top import mem_pkg::*; #(
    parameter int ram_addr_w = 10
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    input  mem_op_t     in_op,
    input  logic [31:0] in_addr,
    input  logic [31:0] in_rt,
    input  logic [4:0]  in_dest,
    input  logic [31:0] in_pc,
    output logic        rf_we,
    output logic [4:0]  rf_waddr,
    output logic [31:0] rf_wdata,
    output logic        exc_valid,
    output logic [4:0]  exc_code,
    output logic [31:0] exc_epc,
    output logic [31:0] exc_badvaddr,
    output logic [4:0]  mem_fwd_dest,
    output logic [31:0] mem_fwd_data
);

    logic                  flush;

    logic                  ram_en;
    logic [3:0]            ram_we;
    logic [ram_addr_w-1:0] ram_addr;
    logic [31:0]           ram_wdata;
    logic [31:0]           ram_rdata;

    logic                  is_valid;
    mem_op_t               is_op;
    logic [31:0]           is_addr;
    logic [31:0]           is_rt;
    logic [4:0]            is_dest;
    logic [31:0]           is_pc;
    logic                  is_ex;
    logic [4:0]            is_exc_code;

    logic                  ms_valid;
    logic                  ms_we;
    logic [4:0]            ms_dest;
    logic [31:0]           ms_result;
    logic [31:0]           ms_pc;
    logic                  ms_ex;
    logic [4:0]            ms_exc_code;
    logic [31:0]           ms_badvaddr;

    store_align #(.ram_addr_w(ram_addr_w)) u_store_align (.*);

    data_ram #(.ram_addr_w(ram_addr_w)) u_data_ram (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    mem_stage u_mem_stage (.*);

    wb_stage u_wb_stage (.*);

endmodule

// ==== design/mem_pkg.sv ====
package mem_pkg;

    // memory operation seen by the back end
    typedef enum logic [3:0] {
        op_alu,     // result is the address field, no memory access
        op_lw,
        op_lb,
        op_lbu,
        op_lh,
        op_lhu,
        op_lwl,
        op_lwr,
        op_sw,
        op_sb,
        op_sh,
        op_swl,
        op_swr
    } mem_op_t;

    // one RAM word, seen as byte lanes or halfword lanes
    typedef union packed {
        logic [3:0][7:0]  b;
        logic [1:0][15:0] h;
    } word_lanes_u;

    localparam logic [4:0] exc_adel = 5'd4; // address error on load
    localparam logic [4:0] exc_ades = 5'd5; // address error on store

    function automatic logic op_is_load(mem_op_t op);
        return op inside {op_lw, op_lb, op_lbu, op_lh, op_lhu, op_lwl, op_lwr};
    endfunction

    function automatic logic op_is_store(mem_op_t op);
        return op inside {op_sw, op_sb, op_sh, op_swl, op_swr};
    endfunction

endpackage

// ==== design/mem_stage.sv ====
module mem_stage import mem_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        flush,
    input  logic        is_valid,
    input  mem_op_t     is_op,
    input  logic [31:0] is_addr,
    input  logic [31:0] is_rt,
    input  logic [4:0]  is_dest,
    input  logic [31:0] is_pc,
    input  logic        is_ex,
    input  logic [4:0]  is_exc_code,
    input  logic [31:0] ram_rdata,
    output logic        ms_valid,
    output logic        ms_we,
    output logic [4:0]  ms_dest,
    output logic [31:0] ms_result,
    output logic [31:0] ms_pc,
    output logic        ms_ex,
    output logic [4:0]  ms_exc_code,
    output logic [31:0] ms_badvaddr,
    output logic [4:0]  mem_fwd_dest,
    output logic [31:0] mem_fwd_data
);

    mem_op_t     ms_op;
    logic [31:0] ms_addr;
    logic [31:0] ms_rt;      // old rt value for the lwl/lwr merge
    logic [1:0]  off;
    word_lanes_u rd;
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;
    logic [31:0] lwl_data;
    logic [31:0] lwr_data;
    logic [31:0] load_data;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ms_valid <= 1'b0;
            ms_ex    <= 1'b0;
        end else begin
            ms_valid <= is_valid;
            ms_ex    <= is_ex;
        end
    end

    always_ff @(posedge clk) begin
        ms_op       <= is_op;
        ms_addr     <= is_addr;
        ms_rt       <= is_rt;
        ms_dest     <= is_dest;
        ms_pc       <= is_pc;
        ms_exc_code <= is_exc_code;
    end

    assign rd       = ram_rdata; // read word arrives with this register
    assign off      = ms_addr[1:0];
    assign sel_byte = rd.b[off];
    assign sel_half = rd.h[off[1]];

    // lwl fills rt from the top with memory bytes 0..off
    always_comb begin
        case (off)
            2'd0:    lwl_data = {rd.b[0], ms_rt[23:0]};
            2'd1:    lwl_data = {rd.h[0], ms_rt[15:0]};
            2'd2:    lwl_data = {ram_rdata[23:0], ms_rt[7:0]};
            default: lwl_data = ram_rdata;
        endcase
    end

    // lwr fills rt from the bottom with memory bytes off..3
    always_comb begin
        case (off)
            2'd0:    lwr_data = ram_rdata;
            2'd1:    lwr_data = {ms_rt[31:24], ram_rdata[31:8]};
            2'd2:    lwr_data = {ms_rt[31:16], rd.h[1]};
            default: lwr_data = {ms_rt[31:8], rd.b[3]};
        endcase
    end

    always_comb begin
        case (ms_op)
            op_lb:   load_data = {{24{sel_byte[7]}}, sel_byte};
            op_lbu:  load_data = {24'd0, sel_byte};
            op_lh:   load_data = {{16{sel_half[15]}}, sel_half};
            op_lhu:  load_data = {16'd0, sel_half};
            op_lwl:  load_data = lwl_data;
            op_lwr:  load_data = lwr_data;
            default: load_data = ram_rdata; // lw
        endcase
    end

    assign ms_result   = op_is_load(ms_op) ? load_data : ms_addr;
    assign ms_badvaddr = ms_addr;

    // faulting ops and stores write no register
    assign ms_we = ms_valid && !ms_ex && (ms_op == op_alu || op_is_load(ms_op));

    assign mem_fwd_dest = ms_we ? ms_dest : 5'd0;
    assign mem_fwd_data = ms_result;

endmodule

// ==== design/store_align.sv ====
module store_align import mem_pkg::*; #(
    parameter int ram_addr_w = 10
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  logic                  in_valid,
    input  mem_op_t               in_op,
    input  logic [31:0]           in_addr,
    input  logic [31:0]           in_rt,
    input  logic [4:0]            in_dest,
    input  logic [31:0]           in_pc,
    output logic                  ram_en,
    output logic [3:0]            ram_we,
    output logic [ram_addr_w-1:0] ram_addr,
    output logic [31:0]           ram_wdata,
    output logic                  is_valid,
    output mem_op_t               is_op,
    output logic [31:0]           is_addr,
    output logic [31:0]           is_rt,
    output logic [4:0]            is_dest,
    output logic [31:0]           is_pc,
    output logic                  is_ex,
    output logic [4:0]            is_exc_code
);

    logic        ex_shadow;   // op right behind a fault, keep it off the RAM
    logic [1:0]  off;
    logic        misalign;
    logic [3:0]  be;
    word_lanes_u st_lanes;

    always_ff @(posedge clk) begin
        if (reset) begin
            is_valid  <= 1'b0;
            ex_shadow <= 1'b0;
        end else begin
            is_valid  <= in_valid && !flush;
            ex_shadow <= is_ex && !flush;
        end
    end

    always_ff @(posedge clk) begin
        is_op   <= in_op;
        is_addr <= in_addr;
        is_rt   <= in_rt;
        is_dest <= in_dest;
        is_pc   <= in_pc;
    end

    assign off = is_addr[1:0];

    always_comb begin
        case (is_op)
            op_lw, op_sw:         misalign = (off != 2'b00);
            op_lh, op_lhu, op_sh: misalign = off[0];
            default:              misalign = 1'b0; // byte and partial word ops never fault
        endcase
    end

    assign is_ex       = is_valid && misalign;
    assign is_exc_code = !is_ex ? 5'd0 : (op_is_store(is_op) ? exc_ades : exc_adel);

    // lane enables and store data placement, little-endian offset
    always_comb begin
        st_lanes = is_rt;
        be       = 4'b0000;
        case (is_op)
            op_sw: be = 4'b1111;
            op_sb: begin
                st_lanes.b = {4{is_rt[7:0]}};
                be         = 4'b0001 << off;
            end
            op_sh: begin
                st_lanes.h = {2{is_rt[15:0]}};
                be         = off[1] ? 4'b1100 : 4'b0011;
            end
            op_swl: begin
                st_lanes = is_rt >> {~off, 3'b000}; // top bytes of rt down to byte 0
                be       = 4'b1111 >> ~off;
            end
            op_swr: begin
                st_lanes = is_rt << {off, 3'b000}; // low bytes of rt up to byte 3
                be       = 4'b1111 << off;
            end
            default: ;
        endcase
    end

    assign ram_en = is_valid && !is_ex && !flush && !ex_shadow
                    && (op_is_load(is_op) || op_is_store(is_op));
    assign ram_we    = (ram_en && op_is_store(is_op)) ? be : 4'b0000;
    assign ram_addr  = is_addr[ram_addr_w+1:2]; // upper bits dropped, addresses wrap
    assign ram_wdata = st_lanes;

endmodule

// ==== design/wb_stage.sv ====
module wb_stage (
    input  logic        clk,
    input  logic        reset,
    input  logic        ms_valid,
    input  logic        ms_we,
    input  logic [4:0]  ms_dest,
    input  logic [31:0] ms_result,
    input  logic [31:0] ms_pc,
    input  logic        ms_ex,
    input  logic [4:0]  ms_exc_code,
    input  logic [31:0] ms_badvaddr,
    output logic        rf_we,
    output logic [4:0]  rf_waddr,
    output logic [31:0] rf_wdata,
    output logic        flush,
    output logic        exc_valid,
    output logic [4:0]  exc_code,
    output logic [31:0] exc_epc,
    output logic [31:0] exc_badvaddr
);

    logic        take_ex;
    logic [31:0] rf [1:31]; // rd0 has no storage and reads as zero

    // the op arriving during flush is a younger one, drop it
    assign take_ex = ms_valid && ms_ex && !flush;

    always_ff @(posedge clk) begin
        if (reset) begin
            rf_we     <= 1'b0;
            flush     <= 1'b0;
            exc_valid <= 1'b0;
        end else begin
            rf_we     <= ms_valid && ms_we && !flush && (ms_dest != 5'd0);
            flush     <= take_ex;   // one cycle pulse
            exc_valid <= take_ex;
        end
    end

    always_ff @(posedge clk) begin
        rf_waddr <= ms_dest;
        rf_wdata <= ms_result;
    end

    // exception record, held until the next fault
    always_ff @(posedge clk) begin
        if (take_ex) begin
            exc_code     <= ms_exc_code;
            exc_epc      <= ms_pc;
            exc_badvaddr <= ms_badvaddr;
        end
    end

    always_ff @(posedge clk) begin
        if (rf_we) begin
            rf[rf_waddr] <= rf_wdata;
        end
    end

endmodule

// ==== tests/lsu_pipe_checker.sv ====
module lsu_pipe_checker (
    input logic        clk,
    input logic        reset,
    input logic        rf_we,
    input logic [4:0]  rf_waddr,
    input logic [31:0] rf_wdata,
    input logic        exc_valid,
    input logic [4:0]  exc_code,
    input logic [31:0] exc_epc,
    input logic [31:0] exc_badvaddr,
    input logic [4:0]  mem_fwd_dest,
    input logic [31:0] mem_fwd_data
);

    logic [36:0] wr_q[$];    // {dest, data}
    logic [68:0] ex_q[$];    // {code, epc, badvaddr}
    logic [36:0] wr_exp;
    logic [68:0] ex_exp;
    logic [4:0]  fwd_dest_d; // forwarding seen one cycle before writeback
    logic [31:0] fwd_data_d;
    logic [31:0] rf_exp [1:31];  // register image after every expected write
    logic [31:1] rf_seen = '0;
    int          mismatches = 0;
    int          unexpected = 0;
    int          leftover = 0;

    task automatic expect_write(input logic [4:0] dest, input logic [31:0] data);
        wr_q.push_back({dest, data});
    endtask

    task automatic expect_exc(input logic [4:0] code, input logic [31:0] epc,
                              input logic [31:0] badvaddr);
        ex_q.push_back({code, epc, badvaddr});
    endtask

    function automatic int pending();
        return wr_q.size() + ex_q.size();
    endfunction

    task automatic report_leftover();
        if (pending() != 0) begin
            $display("%0d expected writes and %0d expected exceptions never appeared",
                     wr_q.size(), ex_q.size());
            leftover = pending();
        end
    endtask

    // internal register file against the writes seen so far
    task automatic check_regfile();
        for (int r = 1; r < 32; r++) begin
            if (rf_seen[r] && lsu_pipe_tb.UUT.u_wb_stage.rf[r] !== rf_exp[r]) begin
                $display("FAILED at %0t: register file r%0d = %h, expected %h", $time, r,
                         lsu_pipe_tb.UUT.u_wb_stage.rf[r], rf_exp[r]);
                mismatches++;
            end
        end
    endtask

    always @(negedge clk) begin
        if (!reset && rf_we) begin
            if (wr_q.size() == 0) begin
                $display("unexpected write of r%0d = %h at time %0t", rf_waddr, rf_wdata, $time);
                unexpected++;
            end else begin
                wr_exp = wr_q.pop_front();
                rf_exp[wr_exp[36:32]]  = wr_exp[31:0];
                rf_seen[wr_exp[36:32]] = 1'b1;
                if (rf_waddr !== wr_exp[36:32] || rf_wdata !== wr_exp[31:0]) begin
                    $display("FAILED at %0t: write r%0d = %h, expected r%0d = %h", $time,
                             rf_waddr, rf_wdata, wr_exp[36:32], wr_exp[31:0]);
                    mismatches++;
                end
                if (fwd_dest_d !== wr_exp[36:32] || fwd_data_d !== wr_exp[31:0]) begin
                    $display("FAILED at %0t: forwarded r%0d = %h, expected r%0d = %h", $time,
                             fwd_dest_d, fwd_data_d, wr_exp[36:32], wr_exp[31:0]);
                    mismatches++;
                end
            end
        end
        if (!reset && exc_valid) begin
            if (ex_q.size() == 0) begin
                $display("unexpected exception, epc %h, at time %0t", exc_epc, $time);
                unexpected++;
            end else begin
                ex_exp = ex_q.pop_front();
                if ({exc_code, exc_epc, exc_badvaddr} !== ex_exp) begin
                    $display("FAILED at %0t: exception %0d/%h/%h, expected %0d/%h/%h",
                             $time, exc_code, exc_epc, exc_badvaddr,
                             ex_exp[68:64], ex_exp[63:32], ex_exp[31:0]);
                    mismatches++;
                end
            end
        end
        fwd_dest_d = mem_fwd_dest;
        fwd_data_d = mem_fwd_data;
    end

endmodule

// ==== tests/lsu_pipe_props.sv ====
module lsu_pipe_props (
    input logic       clk,
    input logic       reset,
    input logic       flush,
    input logic       rf_we,
    input logic [4:0] rf_waddr,
    input logic       exc_valid,
    input logic       ram_en,
    input logic [3:0] ram_we
);

    int fail_count = 0;

    flush_single: assert property (@(posedge clk) disable iff (reset) flush |=> !flush)
        else begin
            $error("flush stayed high for more than one cycle");
            fail_count++;
        end

    no_r0_write: assert property (@(posedge clk) disable iff (reset) rf_we |-> rf_waddr != 5'd0)
        else begin
            $error("register 0 written");
            fail_count++;
        end

    wr_or_exc: assert property (@(posedge clk) disable iff (reset) !(rf_we && exc_valid))
        else begin
            $error("register write and exception in the same cycle");
            fail_count++;
        end

    we_needs_en: assert property (@(posedge clk) disable iff (reset) !ram_en |-> ram_we == 4'b0000)
        else begin
            $error("RAM byte enables set while the RAM is idle");
            fail_count++;
        end

endmodule

bind lsu_pipe_top lsu_pipe_props u_props (.*);

// ==== tests/lsu_pipe_tb.sv ====
module lsu_pipe_tb import mem_pkg::*; ();

    typedef struct packed {
        mem_op_t     op;
        logic [31:0] addr;
        logic [31:0] rt;
        logic [4:0]  dest;
        logic [31:0] pc;
        logic        exp_wr;
        logic        exp_ex;
        logic [4:0]  exp_code;
        logic [31:0] exp_data;
    } entry_t;

    logic        clk;
    logic        reset;
    logic        in_valid;
    mem_op_t     in_op;
    logic [31:0] in_addr;
    logic [31:0] in_rt;
    logic [4:0]  in_dest;
    logic [31:0] in_pc;
    logic        rf_we;
    logic [4:0]  rf_waddr;
    logic [31:0] rf_wdata;
    logic        exc_valid;
    logic [4:0]  exc_code;
    logic [31:0] exc_epc;
    logic [31:0] exc_badvaddr;
    logic [4:0]  mem_fwd_dest;
    logic [31:0] mem_fwd_data;

    entry_t      stim[$];
    logic [7:0]  mdl_mem [0:255]; // byte image of the 64 word RAM
    int          shadow;          // ops still swallowed by a flush
    int          timeouts;
    int          waited;
    int          total;

    lsu_pipe_top #(.ram_addr_w(6)) UUT (.*);

    lsu_pipe_checker chk (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] fill_word(input logic [7:0] b);
        return {b + 8'd3, b + 8'd2, b + 8'd1, b} ^ 32'h3c3c_3c3c;
    endfunction

    // expected effect of one op; byte offset counts up from the low lane
    task automatic model_op(inout entry_t e);
        logic [7:0]  a;
        logic [7:0]  base;
        logic [31:0] rt;
        logic [31:0] d;
        int          off;
        logic        bad;
        a    = e.addr[7:0];   // upper address bits wrap
        base = {e.addr[7:2], 2'b00};
        rt   = e.rt;
        d    = rt;
        off  = e.addr[1:0];
        e.exp_wr = 1'b0;
        e.exp_ex = 1'b0;
        if (shadow > 0) begin
            shadow--;
            return;
        end
        case (e.op)
            op_lw, op_sw:         bad = (off != 0);
            op_lh, op_lhu, op_sh: bad = (off % 2 == 1);
            default:              bad = 1'b0;
        endcase
        if (bad) begin
            e.exp_ex   = 1'b1;
            e.exp_code = (e.op == op_sw || e.op == op_sh) ? 5'd5 : 5'd4;
            shadow     = 3;
            return;
        end
        case (e.op)
            op_alu: d = e.addr;
            op_lw:  d = {mdl_mem[base+3], mdl_mem[base+2], mdl_mem[base+1], mdl_mem[base]};
            op_lb:  d = {{24{mdl_mem[a][7]}}, mdl_mem[a]};
            op_lbu: d = {24'd0, mdl_mem[a]};
            op_lh:  d = {{16{mdl_mem[a+1][7]}}, mdl_mem[a+1], mdl_mem[a]};
            op_lhu: d = {16'd0, mdl_mem[a+1], mdl_mem[a]};
            op_lwl: for (int j = 0; j <= off; j++) begin
                d[8*(3-off+j) +: 8] = mdl_mem[base+j]; // memory bytes into the top of rt
            end
            op_lwr: for (int j = off; j < 4; j++) begin
                d[8*(j-off) +: 8] = mdl_mem[base+j];
            end
            op_sw:  for (int j = 0; j < 4; j++) begin
                mdl_mem[base+j] = rt[8*j +: 8];
            end
            op_sb:  mdl_mem[a] = rt[7:0];
            op_sh:  begin
                mdl_mem[a]   = rt[7:0];
                mdl_mem[a+1] = rt[15:8];
            end
            op_swl: for (int j = 0; j <= off; j++) begin
                mdl_mem[base+j] = rt[8*(3-off+j) +: 8];
            end
            op_swr: for (int j = off; j < 4; j++) begin
                mdl_mem[base+j] = rt[8*(j-off) +: 8];
            end
            default: ;
        endcase
        e.exp_data = d;
        e.exp_wr   = (e.op inside {op_alu, op_lw, op_lb, op_lbu, op_lh, op_lhu, op_lwl, op_lwr})
                     && e.dest != 5'd0;
    endtask

    task automatic add_op(input mem_op_t op, input logic [31:0] addr,
                          input logic [31:0] rt, input logic [4:0] dest);
        entry_t e;
        e      = '0;
        e.op   = op;
        e.addr = addr;
        e.rt   = rt;
        e.dest = dest;
        e.pc   = 32'h0040_0000 + 32'(4 * stim.size());
        model_op(e);
        stim.push_back(e);
    endtask

    task automatic build_table();
        mem_op_t     bad_op [4] = '{op_lw, op_lh, op_sw, op_sh};
        logic [31:0] seed;
        logic [31:0] a;
        mem_op_t     op;
        for (int i = 0; i < 64; i++) begin
            add_op(op_sw, 4 * i, fill_word(8'(4 * i)), 5'd0); // no RAM word left unknown
        end
        add_op(op_sw, 32'h40, 32'hdead_beef, 5'd0);
        add_op(op_lw, 32'h40, 32'h0, 5'd1);
        add_op(op_lw, 32'h8000_0140, 32'h0, 5'd2);    // wraps onto the same word
        for (int o = 0; o < 4; o++) begin
            add_op(op_sb, 32'h80 + o, 32'h3f + 32'h40 * o, 5'd0);
        end
        add_op(op_sh, 32'h84, 32'h1234_8001, 5'd0);
        add_op(op_sh, 32'h86, 32'hffff_7ffe, 5'd0);
        for (int o = 0; o < 4; o++) begin
            add_op(op_lb, 32'h80 + o, 32'h0, 5'd3);
            add_op(op_lbu, 32'h80 + o, 32'h0, 5'd4);
            add_op(op_lh, 32'h84 + 2 * (o % 2), 32'h0, 5'd5);
            add_op(op_lhu, 32'h84 + 2 * (o % 2), 32'h0, 5'd6);
        end
        for (int o = 0; o < 4; o++) begin
            add_op(op_swl, 32'h90 + 5 * o, 32'ha1b2_c3d4, 5'd0);
            add_op(op_swr, 32'hb0 + 5 * o, 32'h1122_3344, 5'd0);
        end
        for (int o = 0; o < 4; o++) begin
            add_op(op_lwl, 32'h90 + 5 * o, 32'h5a5a_5a5a, 5'd7);
            add_op(op_lwr, 32'h90 + 5 * o, 32'h6b6b_6b6b, 5'd8);
            add_op(op_lwl, 32'hb0 + 5 * o, 32'h7c7c_7c7c, 5'd9);
            add_op(op_lwr, 32'hb0 + 5 * o, 32'h8d8d_8d8d, 5'd10);
        end
        for (int k = 0; k < 4; k++) begin
            add_op(bad_op[k], 32'hc1 + 2 * k, 32'h0bad_0bad, 5'd11);
            add_op(op_sw, 32'hc0, 32'hffff_ffff, 5'd0);   // flushed
            add_op(op_alu, 32'h1111_1111, 32'h0, 5'd12);
            add_op(op_sb, 32'hc4, 32'h0000_00ee, 5'd0);
            add_op(op_lw, 32'hc0, 32'h0, 5'd13);
            add_op(op_lw, 32'hc4, 32'h0, 5'd14);
        end
        add_op(op_alu, 32'h1234_5678, 32'h0, 5'd15);
        add_op(op_alu, 32'h0bad_f00d, 32'h0, 5'd0);
        add_op(op_lw, 32'h40, 32'h0, 5'd0);
        add_op(op_alu, 32'hffff_fff0, 32'h0, 5'd31);
        seed = 32'h20cb_5efd;
        for (int i = 0; i < 200; i++) begin
            seed = xorshift32(seed);
            op   = mem_op_t'(4'(seed % 13));
            a    = xorshift32(seed ^ 32'h9e37_79b9);
            if (seed[7:5] != 3'd0 && op inside {op_lw, op_sw}) begin
                a[1:0] = 2'b00;   // mostly aligned, some faults
            end
            if (seed[7:5] != 3'd0 && op inside {op_lh, op_lhu, op_sh}) begin
                a[0] = 1'b0;
            end
            add_op(op, a, xorshift32(a), seed[12:8]);
        end
    endtask

    initial begin
        clk      = 1'b0;
        reset    = 1'b1;
        in_valid = 1'b0;
        in_op    = op_alu;
        in_addr  = 32'd0;
        in_rt    = 32'd0;
        in_dest  = 5'd0;
        in_pc    = 32'd0;
        shadow   = 0;
        timeouts = 0;
        build_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < stim.size(); i++) begin
            @(negedge clk);
            in_valid = 1'b1;
            in_op    = stim[i].op;
            in_addr  = stim[i].addr;
            in_rt    = stim[i].rt;
            in_dest  = stim[i].dest;
            in_pc    = stim[i].pc;
            if (stim[i].exp_wr) begin
                chk.expect_write(stim[i].dest, stim[i].exp_data);
            end
            if (stim[i].exp_ex) begin
                chk.expect_exc(stim[i].exp_code, stim[i].pc, stim[i].addr);
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
        waited   = 0;
        while (chk.pending() != 0 && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (chk.pending() != 0) begin
            $display("timeout: writeback did not drain within 20 cycles");
            timeouts++;
        end
        repeat (3) @(negedge clk); // room for stray late writes
        chk.report_leftover();
        chk.check_regfile();
        total = chk.mismatches + chk.unexpected + chk.leftover + timeouts
                + UUT.u_props.fail_count;
        $display("errors: %0d mismatch, %0d unexpected, %0d leftover, %0d timeout, %0d assertion",
                 chk.mismatches, chk.unexpected, chk.leftover, timeouts, UUT.u_props.fail_count);
        if (total == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
design/mem_pkg.sv
design/store_align.sv
design/data_ram.sv
design/mem_stage.sv
design/wb_stage.sv
design/lsu_pipe_top.sv
tests/lsu_pipe_props.sv
tests/lsu_pipe_checker.sv
tests/lsu_pipe_tb.sv
